/* common/mcu_proto_pkg.sv */
package mcu_proto_pkg;

    typedef logic [7:0] spi_byte_t;

    localparam spi_byte_t FPGA_ID = 8'h64;

    typedef enum logic [7:0] {
        CMD_IDENTIFY   = 8'd0,
        CMD_REG_READ   = 8'd1,
        CMD_REG_WRITE  = 8'd2,
        CMD_MEM_READ   = 8'd3,
        CMD_MEM_WRITE  = 8'd4,
        CMD_USB_STATUS = 8'd5,
        CMD_USB_READ   = 8'd6,
        CMD_USB_WRITE  = 8'd7
    } cmd_e;

    // position inside a frame
    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

endpackage

/* common/mcu_regs_pkg.sv */
package mcu_regs_pkg;

    // addresses 3 to 5 left unused
    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR     = 8'd1,
        REG_USB_SCR     = 8'd2,
        REG_CFG_SCR     = 8'd6
    } reg_address_e;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [7:0]  address;
        logic [31:0] wdata;
    } reg_access_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [8:0]  index;
        logic [15:0] wdata;
    } buf_access_t;

    typedef struct packed {
        logic       start;
        logic       direction; // 1 = buffer to memory
        logic [8:0] last;      // word count minus one
    } mem_ctrl_t;

    typedef struct packed {
        logic        request;
        logic        write;
        logic [31:0] address;
        logic [15:0] wdata;
    } mem_bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } mem_bus_rsp_t;

    typedef struct packed {
        logic       rx_read;
        logic       tx_write;
        logic [7:0] tx_wdata;
    } fifo_req_t;

    typedef struct packed {
        logic [7:0] rx_rdata;
        logic       rx_empty;
        logic       tx_full;
    } fifo_rsp_t;

    // same bit order as CFG_SCR[11:0]
    typedef struct packed {
        logic rom_extended_enabled;
        logic eeprom_16k_mode;
        logic eeprom_enabled;
        logic ddipl_enabled;
        logic dd_enabled;
        logic flashram_enabled;
        logic sram_banked;
        logic sram_enabled;
        logic rom_shadow_enabled;
        logic rom_write_enabled;
        logic bootloader_skip;
        logic bootloader_enabled;
    } cfg_t;

endpackage

/* mcu_link/mcu_spi_slave.sv */
`timescale 1ns/1ps

module mcu_spi_slave #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      mcu_clk,
    input  logic                      mcu_cs,
    input  logic                      mcu_mosi,
    output logic                      mcu_miso,
    output logic                      frame_start,
    output logic                      data_ready,
    output mcu_proto_pkg::spi_byte_t  rx_data,
    input  mcu_proto_pkg::spi_byte_t  tx_data
);

    logic [SYNC_STAGES-1:0] sclk_ff;
    logic [SYNC_STAGES-1:0] cs_ff;
    logic [SYNC_STAGES-1:0] mosi_ff;
    logic sclk_prev;
    logic cs_prev;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_fall;
    logic cs_active;
    logic [2:0] bit_count;
    logic cs_fall_d;
    logic byte_done;
    logic [2:0] load_pipe;
    mcu_proto_pkg::spi_byte_t tx_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_ff <= '0;
            cs_ff <= '1; // idle deselected
            sclk_prev <= 1'b0;
            cs_prev <= 1'b1;
        end else begin
            sclk_ff <= {sclk_ff[SYNC_STAGES-2:0], mcu_clk};
            cs_ff <= {cs_ff[SYNC_STAGES-2:0], mcu_cs};
            sclk_prev <= sclk_ff[SYNC_STAGES-1];
            cs_prev <= cs_ff[SYNC_STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        mosi_ff <= {mosi_ff[SYNC_STAGES-2:0], mcu_mosi}; // aligned with sclk_ff
    end

    assign sclk_rise = sclk_ff[SYNC_STAGES-1] && !sclk_prev;
    assign sclk_fall = !sclk_ff[SYNC_STAGES-1] && sclk_prev;
    assign cs_fall = !cs_ff[SYNC_STAGES-1] && cs_prev;
    assign cs_active = !cs_ff[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= 3'd0;
            cs_fall_d <= 1'b0;
            frame_start <= 1'b0;
            byte_done <= 1'b0;
            data_ready <= 1'b0;
            load_pipe <= 3'd0;
        end else begin
            cs_fall_d <= cs_fall;
            frame_start <= cs_fall_d;
            byte_done <= cs_active && sclk_rise && (bit_count == 3'd7);
            data_ready <= byte_done;
            load_pipe <= {load_pipe[1:0], data_ready}; // gives the response time to settle
            if (!cs_active) begin
                bit_count <= 3'd0;
            end else if (sclk_rise) begin
                bit_count <= bit_count + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            rx_data <= {rx_data[6:0], mosi_ff[SYNC_STAGES-1]}; // msb first
        end
        // no shift on the falling edge that ends a byte
        if (frame_start || load_pipe[2]) begin
            tx_shift <= tx_data;
        end else if (cs_active && sclk_fall && (bit_count != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign mcu_miso = tx_shift[7];

endmodule

/* mcu_link/mcu_protocol.sv */
`timescale 1ns/1ps

module mcu_protocol (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          frame_start,
    input  logic                          data_ready,
    input  mcu_proto_pkg::spi_byte_t      rx_data,
    output mcu_proto_pkg::spi_byte_t      tx_data,
    output mcu_regs_pkg::reg_access_t     reg_acc,
    input  logic [31:0]                   reg_rdata,
    output mcu_regs_pkg::buf_access_t     buf_acc,
    input  logic [15:0]                   buf_rdata,
    output mcu_regs_pkg::fifo_req_t       fifo_req,
    input  mcu_regs_pkg::fifo_rsp_t       fifo_rsp
);

    mcu_proto_pkg::phase_e phase;
    mcu_proto_pkg::cmd_e cmd;
    logic [1:0] counter;
    logic [7:0] address;
    logic word_select;
    logic reg_read;
    logic reg_write;
    logic [31:0] reg_wdata;
    logic buf_read;
    logic buf_write;
    logic [15:0] buf_wdata;
    mcu_proto_pkg::spi_byte_t usb_rdata;

    assign reg_acc = {reg_read, reg_write, address, reg_wdata};
    assign buf_acc = {buf_read, buf_write, address, word_select, buf_wdata};

    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;
        fifo_req.rx_read <= 1'b0;
        fifo_req.tx_write <= 1'b0;

        if (reset) begin
            phase <= mcu_proto_pkg::PHASE_NOP;
            cmd <= mcu_proto_pkg::CMD_IDENTIFY;
            counter <= 2'd0;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase <= mcu_proto_pkg::PHASE_CMD;
            end

            // buffer address steps once per word pair
            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    mcu_proto_pkg::PHASE_CMD: begin
                        cmd <= mcu_proto_pkg::cmd_e'(rx_data);
                        phase <= mcu_proto_pkg::PHASE_ADDRESS;
                        usb_rdata <= fifo_rsp.rx_rdata; // head before it advances
                        if (rx_data == mcu_proto_pkg::CMD_USB_STATUS) begin
                            phase <= mcu_proto_pkg::PHASE_NOP;
                        end
                        if (rx_data == mcu_proto_pkg::CMD_USB_READ) begin
                            fifo_req.rx_read <= 1'b1;
                            phase <= mcu_proto_pkg::PHASE_DATA;
                        end
                        if (rx_data == mcu_proto_pkg::CMD_USB_WRITE) begin
                            phase <= mcu_proto_pkg::PHASE_DATA;
                        end
                    end

                    mcu_proto_pkg::PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase <= mcu_proto_pkg::PHASE_DATA;
                        reg_read <= (cmd == mcu_proto_pkg::CMD_REG_READ);
                        if (cmd == mcu_proto_pkg::CMD_MEM_READ) begin
                            buf_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    mcu_proto_pkg::PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            mcu_proto_pkg::CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end
                            mcu_proto_pkg::CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: 8] <= rx_data; // lsb first
                                reg_write <= (counter == 2'd3);
                            end
                            mcu_proto_pkg::CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read <= 1'b1;
                                    word_select <= !word_select;
                                end
                            end
                            mcu_proto_pkg::CMD_MEM_WRITE: begin
                                if (!counter[0]) begin
                                    buf_wdata[15:8] <= rx_data;
                                end else begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write <= 1'b1;
                                    word_select <= counter[1];
                                end
                            end
                            mcu_proto_pkg::CMD_USB_READ: begin
                                phase <= mcu_proto_pkg::PHASE_NOP;
                            end
                            mcu_proto_pkg::CMD_USB_WRITE: begin
                                fifo_req.tx_write <= 1'b1;
                                fifo_req.tx_wdata <= rx_data;
                                phase <= mcu_proto_pkg::PHASE_NOP;
                            end
                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // first byte of every frame answers zero
    always_comb begin
        tx_data = 8'h00;
        if (!frame_start) begin
            case (cmd)
                mcu_proto_pkg::CMD_IDENTIFY: tx_data = mcu_proto_pkg::FPGA_ID;
                mcu_proto_pkg::CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: 8];
                mcu_proto_pkg::CMD_MEM_READ: begin
                    tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
                end
                mcu_proto_pkg::CMD_USB_STATUS: begin
                    tx_data = {6'd0, !fifo_rsp.tx_full, !fifo_rsp.rx_empty};
                end
                mcu_proto_pkg::CMD_USB_READ: tx_data = usb_rdata;
                default: tx_data = 8'h00;
            endcase
        end
    end

endmodule

/* mem_bridge/mem_bridge.sv */
`timescale 1ns/1ps

module mem_bridge #(
    parameter int BUFFER_INDEX_BITS = 9
) (
    input  logic                        clk,
    input  logic                        reset,
    input  mcu_regs_pkg::buf_access_t   buf_acc,
    output logic [15:0]                 buf_rdata,
    input  mcu_regs_pkg::mem_ctrl_t     mem_ctrl,
    input  logic [31:0]                 mem_address,
    output logic                        mem_busy,
    output mcu_regs_pkg::mem_bus_req_t  mem_req,
    input  mcu_regs_pkg::mem_bus_rsp_t  mem_rsp
);

    logic [15:0] buffer [2**BUFFER_INDEX_BITS];
    logic [BUFFER_INDEX_BITS-1:0] word_index;
    logic [BUFFER_INDEX_BITS-1:0] last_index;
    logic bus_done;
    logic last_word;

    assign bus_done = mem_busy && mem_req.request && mem_rsp.ack;
    assign last_word = (word_index == last_index);

    always_ff @(posedge clk) begin
        if (buf_acc.read) begin
            buf_rdata <= buffer[buf_acc.index[BUFFER_INDEX_BITS-1:0]];
        end
        if (buf_acc.write) begin
            buffer[buf_acc.index[BUFFER_INDEX_BITS-1:0]] <= buf_acc.wdata;
        end
        if (bus_done && !mem_req.write) begin
            buffer[word_index] <= mem_rsp.rdata; // memory to buffer
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
            mem_req.request <= 1'b0;
        end else begin
            if (mem_ctrl.start && !mem_busy) begin
                mem_busy <= 1'b1;
                mem_req.write <= mem_ctrl.direction;
                mem_req.address <= mem_address;
                word_index <= '0;
                last_index <= mem_ctrl.last[BUFFER_INDEX_BITS-1:0];
            end

            // one idle cycle between words
            if (mem_busy && !mem_req.request) begin
                mem_req.request <= 1'b1;
                mem_req.wdata <= buffer[word_index];
            end

            if (bus_done) begin
                mem_req.request <= 1'b0;
                mem_req.address <= mem_req.address + 32'd2;
                word_index <= word_index + 1'b1;
                if (last_word) begin
                    mem_busy <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/mcu_regs.sv */
`timescale 1ns/1ps

module mcu_regs #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  mcu_regs_pkg::reg_access_t  reg_acc,
    output logic [31:0]                reg_rdata,
    input  logic                       button,
    input  logic                       mem_busy,
    input  mcu_regs_pkg::fifo_rsp_t    fifo_rsp,
    output mcu_regs_pkg::mem_ctrl_t    mem_ctrl,
    output logic [31:0]                mem_address,
    output mcu_regs_pkg::cfg_t         cfg
);

    logic [SYNC_STAGES-1:0] button_ff;
    logic button_sync;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[SYNC_STAGES-2:0], button};
    end

    assign button_sync = button_ff[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (reg_acc.read) begin
            case (mcu_regs_pkg::reg_address_e'(reg_acc.address))
                mcu_regs_pkg::REG_MEM_ADDRESS: begin
                    reg_rdata <= mem_address;
                end

                mcu_regs_pkg::REG_MEM_SCR: begin
                    reg_rdata <= {28'd0, mem_busy, 3'b000};
                end

                mcu_regs_pkg::REG_USB_SCR: begin
                    reg_rdata <= {29'd0, !fifo_rsp.tx_full, !fifo_rsp.rx_empty, 1'b0};
                end

                mcu_regs_pkg::REG_CFG_SCR: begin
                    reg_rdata <= {!button_sync, 19'd0, cfg}; // button is active low
                end

                default: begin
                    reg_rdata <= 32'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        mem_ctrl.start <= 1'b0;

        if (reset) begin
            cfg <= '{bootloader_enabled: 1'b1, default: 1'b0};
        end else if (reg_acc.write) begin
            case (mcu_regs_pkg::reg_address_e'(reg_acc.address))
                mcu_regs_pkg::REG_MEM_ADDRESS: begin
                    mem_address <= reg_acc.wdata;
                end

                mcu_regs_pkg::REG_MEM_SCR: begin
                    mem_ctrl.start <= reg_acc.wdata[0];
                    mem_ctrl.direction <= reg_acc.wdata[2];
                    mem_ctrl.last <= reg_acc.wdata[13:5] - 9'd1; // count to last index
                end

                mcu_regs_pkg::REG_CFG_SCR: begin
                    cfg <= mcu_regs_pkg::cfg_t'(reg_acc.wdata[11:0]);
                end

                default: begin
                end
            endcase
        end
    end

endmodule

/* hw/mcu_top.sv */
`timescale 1ns/1ps

module mcu_top #(
    parameter int BUFFER_INDEX_BITS = 9,
    parameter int SYNC_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mcu_clk,
    input  logic                        mcu_cs,
    input  logic                        mcu_mosi,
    output logic                        mcu_miso,
    input  logic                        button,
    output mcu_regs_pkg::fifo_req_t     fifo_req,
    input  mcu_regs_pkg::fifo_rsp_t     fifo_rsp,
    output mcu_regs_pkg::mem_bus_req_t  mem_req,
    input  mcu_regs_pkg::mem_bus_rsp_t  mem_rsp,
    output mcu_regs_pkg::cfg_t          cfg
);

    logic frame_start;
    logic data_ready;
    mcu_proto_pkg::spi_byte_t rx_data;
    mcu_proto_pkg::spi_byte_t tx_data;
    mcu_regs_pkg::reg_access_t reg_acc;
    logic [31:0] reg_rdata;
    mcu_regs_pkg::buf_access_t buf_acc;
    logic [15:0] buf_rdata;
    mcu_regs_pkg::mem_ctrl_t mem_ctrl;
    logic [31:0] mem_address;
    logic mem_busy;

    mcu_spi_slave #(
        .SYNC_STAGES(SYNC_STAGES)
    ) mcu_spi_slave_inst (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data)
    );

    mcu_protocol mcu_protocol_inst (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .reg_acc(reg_acc),
        .reg_rdata(reg_rdata),
        .buf_acc(buf_acc),
        .buf_rdata(buf_rdata),
        .fifo_req(fifo_req),
        .fifo_rsp(fifo_rsp)
    );

    mcu_regs #(
        .SYNC_STAGES(SYNC_STAGES)
    ) mcu_regs_inst (
        .clk(clk),
        .reset(reset),
        .reg_acc(reg_acc),
        .reg_rdata(reg_rdata),
        .button(button),
        .mem_busy(mem_busy),
        .fifo_rsp(fifo_rsp),
        .mem_ctrl(mem_ctrl),
        .mem_address(mem_address),
        .cfg(cfg)
    );

    mem_bridge #(
        .BUFFER_INDEX_BITS(BUFFER_INDEX_BITS)
    ) mem_bridge_inst (
        .clk(clk),
        .reset(reset),
        .buf_acc(buf_acc),
        .buf_rdata(buf_rdata),
        .mem_ctrl(mem_ctrl),
        .mem_address(mem_address),
        .mem_busy(mem_busy),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

/* verification/tb_mcu_top.sv */
`timescale 1ns/1ps

module tb_mcu_top;

    localparam int HALF_PERIOD = 4;
    localparam int BYTE_GAP = 16;
    localparam int TX_DEPTH = 2;
    localparam int RX_PRELOAD = 4;
    localparam int POLL_LIMIT = 20;

    logic clk;
    logic reset;
    logic mcu_clk;
    logic mcu_cs;
    logic mcu_mosi;
    logic mcu_miso;
    logic button;
    mcu_regs_pkg::fifo_req_t fifo_req;
    mcu_regs_pkg::fifo_rsp_t fifo_rsp = '0;
    mcu_regs_pkg::mem_bus_req_t mem_req;
    mcu_regs_pkg::mem_bus_rsp_t mem_rsp = '0;
    mcu_regs_pkg::cfg_t cfg;

    integer seed = 39;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int errors_at_start = 0;
    int wait_left = 0;
    mcu_proto_pkg::spi_byte_t mosi_q[$];
    mcu_proto_pkg::spi_byte_t miso_q[$];
    logic [7:0] rx_q[$];
    logic [7:0] tx_q[$];
    logic [15:0] word_q[$];
    logic [15:0] read_q[$];
    logic [15:0] mem_model [logic [31:0]];

    mcu_top #(
        .BUFFER_INDEX_BITS(9),
        .SYNC_STAGES(3)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .button(button),
        .fifo_req(fifo_req),
        .fifo_rsp(fifo_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .cfg(cfg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // usb fifo model whose rx head advances the cycle after a read strobe
    always @(negedge clk) begin
        if (fifo_req.rx_read && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
        end
        if (fifo_req.tx_write) begin
            tx_q.push_back(fifo_req.tx_wdata);
        end
        fifo_rsp.rx_empty = (rx_q.size() == 0);
        fifo_rsp.rx_rdata = (rx_q.size() > 0) ? rx_q[0] : 8'h00;
        fifo_rsp.tx_full = (tx_q.size() >= TX_DEPTH);
    end

    // memory model that acks after 1 to 4 cycles
    always @(negedge clk) begin
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
        end else if (mem_req.request) begin
            if (wait_left == 0) begin
                wait_left = 1 + ({$random(seed)} % 4);
            end
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                if (mem_req.write) begin
                    mem_model[mem_req.address] = mem_req.wdata;
                end else if (mem_model.exists(mem_req.address)) begin
                    mem_rsp.rdata = mem_model[mem_req.address];
                end else begin
                    mem_rsp.rdata = 16'h0000;
                end
                mem_rsp.ack = 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // mode 0 master sampling miso just before each rising edge
    task automatic run_frame();
        mcu_proto_pkg::spi_byte_t rx_byte;
        int bit_pos;
        miso_q.delete();
        mcu_cs = 1'b0;
        repeat (BYTE_GAP) @(negedge clk);
        foreach (mosi_q[i]) begin
            rx_byte = 8'h00;
            for (bit_pos = 7; bit_pos >= 0; bit_pos--) begin
                mcu_mosi = mosi_q[i][bit_pos];
                repeat (HALF_PERIOD) @(negedge clk);
                rx_byte = {rx_byte[6:0], mcu_miso};
                mcu_clk = 1'b1;
                repeat (HALF_PERIOD) @(negedge clk);
                mcu_clk = 1'b0;
            end
            miso_q.push_back(rx_byte);
            repeat (BYTE_GAP) @(negedge clk);
        end
        mcu_cs = 1'b1;
        repeat (BYTE_GAP) @(negedge clk);
    endtask

    task automatic reg_write(input logic [7:0] address, input logic [31:0] data);
        int i;
        mosi_q.delete();
        mosi_q.push_back(mcu_proto_pkg::CMD_REG_WRITE);
        mosi_q.push_back(address);
        for (i = 0; i < 4; i++) begin
            mosi_q.push_back(data[8*i +: 8]); // lsb first
        end
        run_frame();
    endtask

    task automatic reg_read(input logic [7:0] address, output logic [31:0] data);
        int i;
        mosi_q.delete();
        mosi_q.push_back(mcu_proto_pkg::CMD_REG_READ);
        mosi_q.push_back(address);
        for (i = 0; i < 4; i++) begin
            mosi_q.push_back(8'h00);
        end
        run_frame();
        data = {miso_q[5], miso_q[4], miso_q[3], miso_q[2]};
    endtask

    // word k lands at buffer index 2*address + k
    task automatic buffer_write(input logic [7:0] address);
        mosi_q.delete();
        mosi_q.push_back(mcu_proto_pkg::CMD_MEM_WRITE);
        mosi_q.push_back(address);
        foreach (word_q[i]) begin
            mosi_q.push_back(word_q[i][15:8]);
            mosi_q.push_back(word_q[i][7:0]);
        end
        run_frame();
    endtask

    task automatic buffer_read(input logic [7:0] address, input int count);
        int i;
        mosi_q.delete();
        read_q.delete();
        mosi_q.push_back(mcu_proto_pkg::CMD_MEM_READ);
        mosi_q.push_back(address);
        for (i = 0; i < 2 * count; i++) begin
            mosi_q.push_back(8'h00);
        end
        run_frame();
        for (i = 0; i < count; i++) begin
            read_q.push_back({miso_q[2 + 2*i], miso_q[3 + 2*i]});
        end
    endtask

    task automatic send_two(input logic [7:0] first, input logic [7:0] second);
        mosi_q.delete();
        mosi_q.push_back(first);
        mosi_q.push_back(second);
        run_frame();
    endtask

    task automatic wait_copy_done();
        logic [31:0] scr;
        int tries;
        tries = 0;
        scr = 32'h0000_0008;
        while (scr[3] && tries < POLL_LIMIT) begin
            reg_read(mcu_regs_pkg::REG_MEM_SCR, scr);
            tries++;
        end
        if (scr[3]) begin
            error_count++;
            $display("memory copy still busy after %0d status reads", POLL_LIMIT);
        end
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] rdata;
        logic [31:0] base;
        logic [7:0] addr;
        logic [7:0] head;
        int i;
        int n;
        int old_size;
        reset = 1'b1;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        button = 1'b0;
        for (i = 0; i < RX_PRELOAD; i++) begin
            rx_q.push_back(8'($random(seed)));
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);

        check_value("cfg", {20'd0, cfg}, 32'h0000_0001);
        check_value("mem_req.request", {31'd0, mem_req.request}, 32'h0);
        send_two(mcu_proto_pkg::CMD_IDENTIFY, 8'h00);
        check_value("miso byte 0", {24'd0, miso_q[0]}, 32'h0);
        check_value("identify", {24'd0, miso_q[1]}, {24'd0, mcu_proto_pkg::FPGA_ID});
        finish_test("reset and identify");

        value = $random(seed);
        reg_write(mcu_regs_pkg::REG_MEM_ADDRESS, value);
        reg_read(mcu_regs_pkg::REG_MEM_ADDRESS, rdata);
        check_value("MEM_ADDRESS", rdata, value);
        value = $random(seed);
        button = value[0];
        value = $random(seed);
        reg_write(mcu_regs_pkg::REG_CFG_SCR, value);
        check_value("cfg", {20'd0, cfg}, {20'd0, value[11:0]});
        reg_read(mcu_regs_pkg::REG_CFG_SCR, rdata);
        check_value("CFG_SCR", rdata, {~button, 19'd0, value[11:0]});
        button = ~button;
        reg_read(mcu_regs_pkg::REG_CFG_SCR, rdata);
        check_value("CFG_SCR", rdata, {~button, 19'd0, value[11:0]});
        reg_read(mcu_regs_pkg::REG_MEM_SCR, rdata);
        check_value("MEM_SCR", rdata, 32'h0);
        reg_read(mcu_regs_pkg::REG_USB_SCR, rdata);
        check_value("USB_SCR", rdata,
                    {29'd0, tx_q.size() < TX_DEPTH, rx_q.size() != 0, 1'b0});
        finish_test("register access");

        n = 3 + {$random(seed)} % 14; // crosses at least one address step
        addr = 8'({$random(seed)} % 200);
        word_q.delete();
        for (i = 0; i < n; i++) begin
            word_q.push_back(16'($random(seed)));
        end
        buffer_write(addr);
        buffer_read(addr, n);
        for (i = 0; i < n; i++) begin
            check_value("buffer word", {16'd0, read_q[i]}, {16'd0, word_q[i]});
        end
        finish_test("buffer write and read");

        n = 1 + {$random(seed)} % 16;
        word_q.delete();
        for (i = 0; i < n; i++) begin
            word_q.push_back(16'($random(seed)));
        end
        buffer_write(8'd0);
        base = {$random(seed)} & 32'h00ff_fffe;
        mem_model.delete();
        reg_write(mcu_regs_pkg::REG_MEM_ADDRESS, base);
        reg_write(mcu_regs_pkg::REG_MEM_SCR, 32'(n << 5) | 32'h5); // start, buffer to memory
        wait_copy_done();
        check_value("memory word count", mem_model.num(), n);
        for (i = 0; i < n; i++) begin
            if (mem_model.exists(base + 32'(2 * i))) begin
                check_value("memory word", {16'd0, mem_model[base + 32'(2 * i)]},
                            {16'd0, word_q[i]});
            end else begin
                error_count++;
                $display("memory word %0d at 0x%08h was never written", i, base + 32'(2 * i));
            end
        end
        if (mem_model.exists(base + 32'(2 * n))) begin
            error_count++;
            $display("copy wrote past its last word");
        end
        finish_test("buffer to memory copy");

        n = 1 + {$random(seed)} % 16;
        base = {$random(seed)} & 32'h00ff_fffe;
        mem_model.delete();
        word_q.delete();
        for (i = 0; i < n; i++) begin
            word_q.push_back(16'($random(seed)));
            mem_model[base + 32'(2 * i)] = word_q[i];
        end
        reg_write(mcu_regs_pkg::REG_MEM_ADDRESS, base);
        reg_write(mcu_regs_pkg::REG_MEM_SCR, 32'(n << 5) | 32'h1);
        wait_copy_done();
        buffer_read(8'd0, n);
        for (i = 0; i < n; i++) begin
            check_value("buffer word", {16'd0, read_q[i]}, {16'd0, word_q[i]});
        end
        finish_test("memory to buffer copy");

        value = {30'd0, tx_q.size() < TX_DEPTH, rx_q.size() != 0};
        send_two(mcu_proto_pkg::CMD_USB_STATUS, 8'h00);
        check_value("usb status", {24'd0, miso_q[1]}, value);
        for (i = 0; i < RX_PRELOAD; i++) begin
            head = rx_q[0];
            old_size = rx_q.size();
            send_two(mcu_proto_pkg::CMD_USB_READ, 8'h00);
            check_value("usb read", {24'd0, miso_q[1]}, {24'd0, head});
            check_value("rx fifo size", rx_q.size(), old_size - 1);
        end
        send_two(mcu_proto_pkg::CMD_USB_STATUS, 8'h00);
        check_value("usb status", {24'd0, miso_q[1]}, 32'h2); // rx drained
        reg_read(mcu_regs_pkg::REG_USB_SCR, rdata);
        check_value("USB_SCR", rdata,
                    {29'd0, tx_q.size() < TX_DEPTH, rx_q.size() != 0, 1'b0});
        for (i = 0; i < TX_DEPTH; i++) begin
            head = 8'($random(seed));
            send_two(mcu_proto_pkg::CMD_USB_WRITE, head);
            check_value("tx fifo size", tx_q.size(), i + 1);
            check_value("usb write", {24'd0, tx_q[tx_q.size() - 1]}, {24'd0, head});
        end
        send_two(mcu_proto_pkg::CMD_USB_STATUS, 8'h00);
        check_value("usb status", {24'd0, miso_q[1]}, 32'h0);
        finish_test("usb fifo");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/mcu_proto_pkg.sv
common/mcu_regs_pkg.sv
mcu_link/mcu_spi_slave.sv
mcu_link/mcu_protocol.sv
mem_bridge/mem_bridge.sv
hw/mcu_regs.sv
hw/mcu_top.sv
verification/tb_mcu_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs tb_mcu_top with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_mcu_top -o sim_tb_mcu_top; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_output=$(./obj_dir/sim_tb_mcu_top); then
    echo "$sim_output"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_output"

if grep -qx "Done: no errors" <<< "$sim_output"; then
    exit 0
fi
exit 1
